// ==== list.f ====
+incdir+test
common/id_queue_pkg.sv
id_table/head_tail_table.sv
linked_data/linked_data_store.sv
linked_data/exists_search.sv
source/queue_control.sv
source/id_queue_top.sv
test/tb_id_queue.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the ID queue testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_id_queue \
    -Mdir obj_dir -o tb_id_queue

./obj_dir/tb_id_queue

// ==== test/id_queue_checks.svh ====
// Compare tasks, reset wait and run reporting of the ID queue testbench, included inside its top module
`ifndef ID_QUEUE_CHECKS_SVH
`define ID_QUEUE_CHECKS_SVH

    // Ends the run as a failure after the cause has been printed
    task automatic stop_with_fail();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // A wrong value names the table row that produced it
    task automatic report_mismatch(input string msg);
        $display("** Error at time %0t: row %0d, %s", $time, row_idx, msg);
        stop_with_fail();
    endtask

    task automatic check_grant(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
        end
    endtask

    // Valid and data are compared together, so a missing ID must also answer with zero data
    task automatic check_oup(input oup_rsp_t got, input oup_rsp_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("oup_o is valid %b data %h, expected valid %b data %h",
                                      got.valid, got.data, exp.valid, exp.data));
        end
    endtask

    task automatic check_exists(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("exists_o is %b, expected %b", got, exp));
        end
    endtask

    // After reset the push grant must come up, since every cell starts out free
    task automatic wait_for_push_grant(input int max_cycles);
        int cycles;
        cycles = 0;
        while (inp_gnt !== 1'b1) begin
            if (cycles == max_cycles) begin
                $display("Timeout: inp_gnt_o stayed low for %0d cycles after reset", max_cycles);
                stop_with_fail();
            end
            @(negedge clk_i);
            cycles++;
        end
    endtask

`endif

// ==== test/tb_id_queue.sv ====
// Testbench of the ID queue, which applies a table of requests and hand-derived responses to the DUT
`default_nettype none

module tb_id_queue import id_queue_pkg::*; ();

    // Outputs are sampled a quarter period after the falling edge, well before the rising edge
    localparam int HALF_PERIOD = 20;
    localparam int CHECK_DELAY = 10;
    localparam int RESET_CYCLES = 5;
    localparam int RESET_TIMEOUT = 10;

    logic        clk_i;
    logic        rst_ni;
    logic        inp_req;
    push_req_t   inp;
    logic        inp_gnt;
    logic        oup_req;
    oup_req_t    oup;
    oup_rsp_t    oup_rsp;
    logic        oup_gnt;
    logic        exists_req;
    exists_req_t ex;
    logic        exists_hit;
    logic        exists_gnt;

    // One table row is the stimulus of one cycle followed by what the DUT must answer
    typedef struct packed {
        logic        inp_req;
        push_req_t   inp;
        logic        oup_req;
        oup_req_t    oup;
        logic        exists_req;
        exists_req_t ex;
        logic        inp_gnt;
        logic        oup_gnt;
        logic        exists_gnt;
        oup_rsp_t    oup_rsp;
        logic        exists_hit;
    } row_t;

    row_t rows[$];
    int   row_idx;

    id_queue_top uut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .inp_req_i    (inp_req),
        .inp_i        (inp),
        .inp_gnt_o    (inp_gnt),
        .oup_req_i    (oup_req),
        .oup_i        (oup),
        .oup_o        (oup_rsp),
        .oup_gnt_o    (oup_gnt),
        .exists_req_i (exists_req),
        .exists_i     (ex),
        .exists_o     (exists_hit),
        .exists_gnt_o (exists_gnt)
    );

    `include "id_queue_checks.svh"

    initial begin
        clk_i = 1'b0;
        forever #HALF_PERIOD clk_i = ~clk_i;
    end

    // A lone push and the grant it must get from the current fill level
    task automatic push_row(input id_t id, input data_t data, input logic gnt);
        row_t r;
        r = '0;
        r.inp_req = 1'b1;
        r.inp = '{id: id, data: data};
        r.inp_gnt = gnt;
        rows.push_back(r);
    endtask

    // A lone output access is always granted while the push grant still shows the fill level
    task automatic out_row(input id_t id, input logic pop, input logic valid, input data_t data,
                           input logic inp_gnt);
        row_t r;
        r = '0;
        r.oup_req = 1'b1;
        r.oup = '{id: id, pop: pop};
        r.inp_gnt = inp_gnt;
        r.oup_gnt = 1'b1;
        r.oup_rsp = '{data: data, valid: valid};
        rows.push_back(r);
    endtask

    // Searches only happen while storage has room
    task automatic search_row(input data_t key, input data_t mask, input logic hit);
        row_t r;
        r = '0;
        r.exists_req = 1'b1;
        r.ex = '{data: key, mask: mask};
        r.inp_gnt = 1'b1;
        r.exists_gnt = 1'b1;
        r.exists_hit = hit;
        rows.push_back(r);
    endtask

    // When push and peek meet in one cycle the push takes it and the output gets nothing
    task automatic race_row(input id_t id, input data_t data, input id_t oup_id);
        row_t r;
        r = '0;
        r.inp_req = 1'b1;
        r.inp = '{id: id, data: data};
        r.oup_req = 1'b1;
        r.oup = '{id: oup_id, pop: 1'b0};
        r.inp_gnt = 1'b1;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Elements of one ID leave in order even with another ID in between
        push_row(2'd0, 16'hA001, 1'b1);
        push_row(2'd0, 16'hB001, 1'b1);
        push_row(2'd1, 16'hC001, 1'b1);
        push_row(2'd0, 16'hA002, 1'b1);
        out_row(2'd0, 1'b1, 1'b1, 16'hA001, 1'b1);
        out_row(2'd0, 1'b1, 1'b1, 16'hB001, 1'b1);
        out_row(2'd0, 1'b1, 1'b1, 16'hA002, 1'b1);
        out_row(2'd1, 1'b1, 1'b1, 16'hC001, 1'b1);
        // Peeks leave the head in place and an absent ID answers valid 0 and data 0
        push_row(2'd2, 16'h2222, 1'b1);
        out_row(2'd2, 1'b0, 1'b1, 16'h2222, 1'b1);
        out_row(2'd2, 1'b0, 1'b1, 16'h2222, 1'b1);
        out_row(2'd3, 1'b0, 1'b0, 16'h0000, 1'b1);
        out_row(2'd2, 1'b1, 1'b1, 16'h2222, 1'b1);
        out_row(2'd2, 1'b1, 1'b0, 16'h0000, 1'b1);
        // The pushed element is visible one cycle after the contended cycle
        race_row(2'd3, 16'h3333, 2'd3);
        out_row(2'd3, 1'b1, 1'b1, 16'h3333, 1'b1);
        // Eight pushes fill every cell and the ninth is refused
        for (int i = 0; i < CAPACITY; i++) begin
            push_row(2'd1, data_t'(16'h1101 + i), 1'b1);
        end
        push_row(2'd1, 16'h1109, 1'b0);
        out_row(2'd1, 1'b0, 1'b1, 16'h1101, 1'b0);
        out_row(2'd1, 1'b1, 1'b1, 16'h1101, 1'b0);
        for (int i = 1; i < CAPACITY; i++) begin
            out_row(2'd1, 1'b1, 1'b1, data_t'(16'h1101 + i), 1'b1);
        end
        // Nothing of the refused push was stored
        out_row(2'd1, 1'b1, 1'b0, 16'h0000, 1'b1);
        // The key differs from the element only in the upper byte
        push_row(2'd0, 16'h5A3C, 1'b1);
        search_row(16'hC33C, 16'h00FF, 1'b1);
        search_row(16'hC33C, 16'hFFFF, 1'b0);
        out_row(2'd0, 1'b1, 1'b1, 16'h5A3C, 1'b1);
        search_row(16'hC33C, 16'h00FF, 1'b0);
        // All four rows fill up before ID 2 drains and takes a row again
        for (int i = 0; i < NUM_IDS; i++) begin
            push_row(id_t'(i), data_t'(16'h6000 + i), 1'b1);
        end
        out_row(2'd2, 1'b1, 1'b1, 16'h6002, 1'b1);
        push_row(2'd2, 16'h6012, 1'b1);
        push_row(2'd2, 16'h6022, 1'b1);
        out_row(2'd2, 1'b1, 1'b1, 16'h6012, 1'b1);
        out_row(2'd2, 1'b1, 1'b1, 16'h6022, 1'b1);
        out_row(2'd0, 1'b1, 1'b1, 16'h6000, 1'b1);
        out_row(2'd1, 1'b1, 1'b1, 16'h6001, 1'b1);
        out_row(2'd3, 1'b1, 1'b1, 16'h6003, 1'b1);
    endtask

    task automatic drive_row(input row_t r);
        inp_req = r.inp_req;
        inp = r.inp;
        oup_req = r.oup_req;
        oup = r.oup;
        exists_req = r.exists_req;
        ex = r.ex;
    endtask

    initial begin
        rst_ni = 1'b0;
        drive_row('0);
        row_idx = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        wait_for_push_grant(RESET_TIMEOUT);
        for (int i = 0; i < rows.size(); i++) begin
            row_idx = i;
            @(negedge clk_i);
            drive_row(rows[i]);
            #CHECK_DELAY;
            check_grant("inp_gnt_o", inp_gnt, rows[i].inp_gnt);
            check_grant("oup_gnt_o", oup_gnt, rows[i].oup_gnt);
            check_grant("exists_gnt_o", exists_gnt, rows[i].exists_gnt);
            check_oup(oup_rsp, rows[i].oup_rsp);
            check_exists(exists_hit, rows[i].exists_hit);
        end
        @(negedge clk_i);
        drive_row('0);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/id_queue_top.sv ====
// Top level of the ID queue, which joins the control, both tables and the exists search
`default_nettype none

module id_queue_top import id_queue_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic        inp_req_i,
    input  wire push_req_t   inp_i,
    output logic             inp_gnt_o,
    input  wire logic        oup_req_i,
    input  wire oup_req_t    oup_i,
    output oup_rsp_t         oup_o,
    output logic             oup_gnt_o,
    input  wire logic        exists_req_i,
    input  wire exists_req_t exists_i,
    output logic             exists_o,
    output logic             exists_gnt_o
);

    // Lookup path between control and the head/tail table
    id_t        lookup_id;
    ht_lookup_t lookup;
    ht_cmd_t    ht_cmd;

    // State of the linked storage as seen by control
    ld_cmd_t      ld_cmd;
    logic         full;
    ld_idx_t      free_cell;
    linked_data_t head_cell;

    // The whole cell array, which the exists search scans
    linked_data_t [CAPACITY-1:0] cells;

    queue_control u_control (
        .inp_req_i   (inp_req_i),
        .inp_i       (inp_i),
        .oup_req_i   (oup_req_i),
        .oup_i       (oup_i),
        .full_i      (full),
        .lookup_i    (lookup),
        .free_cell_i (free_cell),
        .head_cell_i (head_cell),
        .inp_gnt_o   (inp_gnt_o),
        .oup_gnt_o   (oup_gnt_o),
        .oup_o       (oup_o),
        .lookup_id_o (lookup_id),
        .ht_cmd_o    (ht_cmd),
        .ld_cmd_o    (ld_cmd)
    );

    head_tail_table u_ht_table (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lookup_id_i (lookup_id),
        .lookup_o    (lookup),
        .cmd_i       (ht_cmd)
    );

    // The head of the looked-up ID selects which cell is read out
    linked_data_store u_ld_store (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cmd_i       (ld_cmd),
        .head_idx_i  (lookup.head),
        .head_cell_o (head_cell),
        .free_cell_o (free_cell),
        .full_o      (full),
        .cells_o     (cells)
    );

    exists_search u_exists (
        .cells_i      (cells),
        .exists_req_i (exists_req_i),
        .exists_i     (exists_i),
        .exists_o     (exists_o),
        .exists_gnt_o (exists_gnt_o)
    );

endmodule

`default_nettype wire

// ==== source/queue_control.sv ====
// Arbitrates the push port against the output port and turns the granted access into table commands
`default_nettype none

module queue_control import id_queue_pkg::*; (
    input  wire logic         inp_req_i,
    input  wire push_req_t    inp_i,
    input  wire logic         oup_req_i,
    input  wire oup_req_t     oup_i,
    input  wire logic         full_i,
    input  wire ht_lookup_t   lookup_i,
    input  wire ld_idx_t      free_cell_i,
    input  wire linked_data_t head_cell_i,
    output logic              inp_gnt_o,
    output logic              oup_gnt_o,
    output oup_rsp_t          oup_o,
    output id_t               lookup_id_o,
    output ht_cmd_t           ht_cmd_o,
    output ld_cmd_t           ld_cmd_o
);

    logic push;

    // A push is accepted whenever a cell is free
    assign inp_gnt_o = !full_i;
    assign push = inp_req_i && inp_gnt_o;

    // Only one access per cycle, and the push port wins
    assign oup_gnt_o = oup_req_i && !push;

    // The table is searched for the ID of whichever port is served
    assign lookup_id_o = push ? inp_i.id : oup_i.id;

    always_comb begin
        ht_cmd_o = '{op: HT_NONE, id: '0, idx: '0};
        ld_cmd_o = '0;
        oup_o = '0;

        if (push) begin
            // The new element always lands in the lowest free cell
            ld_cmd_o.alloc = 1'b1;
            ld_cmd_o.data = inp_i.data;
            ht_cmd_o.id = inp_i.id;
            ht_cmd_o.idx = free_cell_i;
            if (lookup_i.hit) begin
                // Existing list, so chain the old tail to the new cell
                ht_cmd_o.op = HT_APPEND;
                ld_cmd_o.link = 1'b1;
                ld_cmd_o.tail = lookup_i.tail;
            end else begin
                ht_cmd_o.op = HT_CREATE;
            end
        end else if (oup_gnt_o && lookup_i.hit) begin
            // The head cell is the oldest element of this ID
            oup_o.valid = 1'b1;
            oup_o.data = head_cell_i.data;
            if (oup_i.pop) begin
                ld_cmd_o.dealloc = 1'b1;
                ld_cmd_o.head = lookup_i.head;
                ht_cmd_o.id = oup_i.id;
                if (lookup_i.head == lookup_i.tail) begin
                    // Last element of the ID, so the row goes back to the pool
                    ht_cmd_o.op = HT_RELEASE;
                end else begin
                    ht_cmd_o.op = HT_ADVANCE;
                    ht_cmd_o.idx = head_cell_i.next;
                end
            end
        end
        // A missing ID is still granted and answers with an all-zero response
    end

endmodule

`default_nettype wire

// ==== linked_data/exists_search.sv ====
// Masked search of a key over every occupied cell, independent of the push and output ports
`default_nettype none

module exists_search import id_queue_pkg::*; (
    input  wire linked_data_t [CAPACITY-1:0] cells_i,
    input  wire logic                        exists_req_i,
    input  wire exists_req_t                 exists_i,
    output logic                             exists_o,
    output logic                             exists_gnt_o
);

    logic [CAPACITY-1:0] hit;

    // A cell matches when no unmasked bit differs from the key
    always_comb begin
        for (int i = 0; i < CAPACITY; i++) begin
            hit[i] = !cells_i[i].free &&
                     (((cells_i[i].data ^ exists_i.data) & exists_i.mask) == '0);
        end
    end

    // The search always finishes in one cycle, so every request is granted
    assign exists_gnt_o = exists_req_i;
    assign exists_o = exists_req_i && (|hit);

endmodule

`default_nettype wire

// ==== linked_data/linked_data_store.sv ====
// Linked element storage with free-cell search, full flag and head read, written by control commands
`default_nettype none

module linked_data_store import id_queue_pkg::*; (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire ld_cmd_t                cmd_i,
    input  wire ld_idx_t                head_idx_i,
    output linked_data_t                head_cell_o,
    output ld_idx_t                     free_cell_o,
    output logic                        full_o,
    output linked_data_t [CAPACITY-1:0] cells_o
);

    // Element payload and list links
    data_t   [CAPACITY-1:0] data_q;
    ld_idx_t [CAPACITY-1:0] next_q;

    // One occupancy flag per cell
    logic    [CAPACITY-1:0] free_q;
    ld_idx_t                free_idx;

    // The lowest free cell is found by scanning downwards
    always_comb begin
        free_idx = '0;
        for (int i = CAPACITY - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                free_idx = ld_idx_t'(i);
            end
        end
    end

    assign free_cell_o = free_idx;
    assign full_o = !(|free_q);

    // Present the cells as one packed array
    always_comb begin
        for (int i = 0; i < CAPACITY; i++) begin
            cells_o[i] = '{data: data_q[i], next: next_q[i], free: free_q[i]};
        end
    end

    assign head_cell_o = cells_o[head_idx_i];

    // The tail is occupied, so link and alloc never write the same cell
    always_ff @(posedge clk_i) begin
        if (cmd_i.link) begin
            next_q[cmd_i.tail] <= free_idx;
        end
        if (cmd_i.alloc) begin
            data_q[free_idx] <= cmd_i.data;
            next_q[free_idx] <= '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            free_q <= '1;
        end else begin
            if (cmd_i.alloc) begin
                free_q[free_idx] <= 1'b0;
            end
            // A freed cell keeps its stale payload until the next alloc
            if (cmd_i.dealloc) begin
                free_q[cmd_i.head] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== id_table/head_tail_table.sv ====
// Per-ID head/tail registers with ID lookup and free-row search, updated by commands from control
`default_nettype none

module head_tail_table import id_queue_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    rst_ni,
    input  wire id_t     lookup_id_i,
    output ht_lookup_t   lookup_o,
    input  wire ht_cmd_t cmd_i
);

    head_tail_t [HT_CAPACITY-1:0] rows_q;
    head_tail_t [HT_CAPACITY-1:0] rows_d;

    // One-hot match of the lookup ID against the occupied rows
    logic [HT_CAPACITY-1:0] match;
    ht_idx_t                match_idx;
    ht_idx_t                free_idx;

    always_comb begin
        for (int i = 0; i < HT_CAPACITY; i++) begin
            match[i] = !rows_q[i].free && (rows_q[i].id == lookup_id_i);
        end
    end

    // At most one row holds a given ID, so a plain encoder is enough
    always_comb begin
        match_idx = '0;
        for (int i = 0; i < HT_CAPACITY; i++) begin
            if (match[i]) begin
                match_idx = ht_idx_t'(i);
            end
        end
    end

    // Scanning downwards leaves the lowest free row selected
    always_comb begin
        free_idx = '0;
        for (int i = HT_CAPACITY - 1; i >= 0; i--) begin
            if (rows_q[i].free) begin
                free_idx = ht_idx_t'(i);
            end
        end
    end

    assign lookup_o.hit = |match;
    assign lookup_o.head = rows_q[match_idx].head;
    assign lookup_o.tail = rows_q[match_idx].tail;

    // Next state of the table
    always_comb begin
        rows_d = rows_q;
        case (cmd_i.op)
            HT_CREATE: begin
                // A fresh ID starts with a one-element list
                rows_d[free_idx] = '{
                    id: cmd_i.id,
                    head: cmd_i.idx,
                    tail: cmd_i.idx,
                    free: 1'b0
                };
            end
            HT_APPEND: begin
                rows_d[match_idx].tail = cmd_i.idx;
            end
            HT_ADVANCE: begin
                rows_d[match_idx].head = cmd_i.idx;
            end
            HT_RELEASE: begin
                rows_d[match_idx] = '{id: '0, head: '0, tail: '0, free: 1'b1};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < HT_CAPACITY; i++) begin
                rows_q[i] <= '{id: '0, head: '0, tail: '0, free: 1'b1};
            end
        end else begin
            rows_q <= rows_d;
        end
    end

endmodule

`default_nettype wire

// ==== common/id_queue_pkg.sv ====
// Shared constants and packed types of the ID queue, imported by every RTL file and the testbench
`default_nettype none

package id_queue_pkg;

    // Widths of an ID and of one stored element
    localparam int ID_WIDTH = 2;
    localparam int DATA_WIDTH = 16;

    // Total number of element cells, shared by all IDs
    localparam int CAPACITY = 8;

    // One head/tail row per ID at most, and never more rows than cells
    localparam int NUM_IDS = 2 ** ID_WIDTH;
    localparam int HT_CAPACITY = (NUM_IDS < CAPACITY) ? NUM_IDS : CAPACITY;
    localparam int HT_IDX_WIDTH = $clog2(HT_CAPACITY);
    localparam int LD_IDX_WIDTH = $clog2(CAPACITY);

    typedef logic [ID_WIDTH-1:0]     id_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [HT_IDX_WIDTH-1:0] ht_idx_t;
    typedef logic [LD_IDX_WIDTH-1:0] ld_idx_t;

    // A row of the head/tail table, free rows hold no ID
    typedef struct packed {
        id_t     id;
        ld_idx_t head;
        ld_idx_t tail;
        logic    free;
    } head_tail_t;

    // A cell of the linked element storage
    typedef struct packed {
        data_t   data;
        ld_idx_t next;
        logic    free;
    } linked_data_t;

    typedef struct packed {
        id_t   id;
        data_t data;
    } push_req_t;

    // With pop cleared the output access is only a peek
    typedef struct packed {
        id_t  id;
        logic pop;
    } oup_req_t;

    typedef struct packed {
        data_t data;
        logic  valid;
    } oup_rsp_t;

    // Only bits set in the mask take part in the comparison
    typedef struct packed {
        data_t data;
        data_t mask;
    } exists_req_t;

    // Result of looking up one ID in the head/tail table
    typedef struct packed {
        logic    hit;
        ld_idx_t head;
        ld_idx_t tail;
    } ht_lookup_t;

    typedef enum logic [2:0] {
        HT_NONE,
        HT_CREATE,
        HT_APPEND,
        HT_ADVANCE,
        HT_RELEASE
    } ht_op_e;

    // The cell index is the new head or tail, depending on the operation
    typedef struct packed {
        ht_op_e  op;
        id_t     id;
        ld_idx_t idx;
    } ht_cmd_t;

    // Alloc fills the free cell, link chains the tail to it, dealloc frees the head
    typedef struct packed {
        logic    alloc;
        data_t   data;
        logic    link;
        ld_idx_t tail;
        logic    dealloc;
        ld_idx_t head;
    } ld_cmd_t;

endpackage

`default_nettype wire
